// File: design/vgaTimingPkg.sv
package vgaTimingPkg;

    // Horizontal timing in pixel clocks
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT = 16;
    localparam int H_SYNC = 96;
    localparam int H_BACK = 48;
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 800

    // Vertical timing in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT = 10;
    localparam int V_SYNC = 2;
    localparam int V_BACK = 33;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 525

    // Sync pulse windows, end is exclusive
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END = V_SYNC_START + V_SYNC;

    typedef logic [9:0] hCount_t;
    typedef logic [9:0] vCount_t;
    typedef logic [11:0] rgb_t;    // 4 bits per channel

    localparam rgb_t FG_COLOR = 12'hfff;
    localparam rgb_t BG_COLOR = 12'h000;

    localparam int PIPE_DELAY = 3; // Render latency in clocks

endpackage

// File: design/charPkg.sv
package charPkg;

    typedef logic [6:0] charCode_t;
    typedef logic [7:0] cellAddr_t;  // Row in upper nibble, column in lower
    typedef logic [2:0] glyphRow_t;
    typedef logic [7:0] glyphBits_t; // Bit 7 is the leftmost pixel

    localparam charCode_t SPACE = 7'd0;
    localparam charCode_t A = 7'd1;
    localparam charCode_t B = 7'd2;
    localparam charCode_t C = 7'd3;
    localparam charCode_t D = 7'd4;
    localparam charCode_t E = 7'd5;
    localparam charCode_t F = 7'd6;
    localparam charCode_t G = 7'd7;
    localparam charCode_t H = 7'd8;
    localparam charCode_t I = 7'd9;
    localparam charCode_t J = 7'd10;
    localparam charCode_t K = 7'd11;
    localparam charCode_t L = 7'd12;
    localparam charCode_t M = 7'd13;
    localparam charCode_t N = 7'd14;
    localparam charCode_t O = 7'd15;
    localparam charCode_t P = 7'd16;
    localparam charCode_t Q = 7'd17;
    localparam charCode_t R = 7'd18;
    localparam charCode_t S = 7'd19;
    localparam charCode_t T = 7'd20;
    localparam charCode_t U = 7'd21;
    localparam charCode_t V = 7'd22;
    localparam charCode_t W = 7'd23;
    localparam charCode_t X = 7'd24;
    localparam charCode_t Y = 7'd25;
    localparam charCode_t Z = 7'd26;

    // Text window at the top-left corner of the screen
    localparam int TEXT_COLS = 16;
    localparam int TEXT_ROWS = 8;
    localparam int CELL_WIDTH = 8;
    localparam int CELL_HEIGHT = 16;  // Each glyph row is shown on two lines
    localparam int WINDOW_WIDTH = TEXT_COLS * CELL_WIDTH;
    localparam int WINDOW_HEIGHT = TEXT_ROWS * CELL_HEIGHT;

endpackage

// File: design/syncGen.sv
`timescale 1ns/1ns

module syncGen (
    input  logic                 clk,
    input  logic                 rst,
    output vgaTimingPkg::hCount_t hCount,
    output vgaTimingPkg::vCount_t vCount,
    output logic                 hsyncRaw,
    output logic                 vsyncRaw,
    output logic                 activeRaw
);

    import vgaTimingPkg::*;

    hCount_t hNext;
    vCount_t vNext;

    // Next position, wraps at end of line and end of frame
    always_comb begin
        hNext = hCount + 1'b1;
        vNext = vCount;
        if (hCount == H_TOTAL - 1) begin
            hNext = '0;
            if (vCount == V_TOTAL - 1) begin
                vNext = '0;
            end else begin
                vNext = vCount + 1'b1;
            end
        end
    end

    // Decode from the next position so the flags line up with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hCount <= '0;
            vCount <= '0;
            hsyncRaw <= 1'b1;
            vsyncRaw <= 1'b1;
            activeRaw <= 1'b0;
        end else begin
            hCount <= hNext;
            vCount <= vNext;
            hsyncRaw <= !(hNext >= H_SYNC_START && hNext < H_SYNC_END); // Active low
            vsyncRaw <= !(vNext >= V_SYNC_START && vNext < V_SYNC_END);
            activeRaw <= (hNext < H_ACTIVE) && (vNext < V_ACTIVE);
        end
    end

endmodule

// File: design/menuTextRom.sv
`timescale 1ns/1ns

module menuTextRom (
    input  logic               clk,
    input  charPkg::cellAddr_t  cellAddr,
    output charPkg::charCode_t  charCode
);

    import charPkg::*;

    charCode_t data;

    always_ff @(posedge clk) begin
        charCode <= data;
    end

    always_comb begin
        case (cellAddr)
            // Row 0
            8'h00: data = SPACE;
            8'h01: data = P;
            8'h02: data = L;
            8'h03: data = A;
            8'h04: data = Y;
            8'h05: data = SPACE;

            // Row 2
            8'h20: data = SPACE;
            8'h21: data = S;
            8'h22: data = C;
            8'h23: data = O;
            8'h24: data = R;
            8'h25: data = E;
            8'h26: data = SPACE;

            default: data = SPACE; // Rest of the window is blank
        endcase
    end

endmodule

// File: design/fontRom.sv
`timescale 1ns/1ns

module fontRom (
    input  logic                clk,
    input  charPkg::charCode_t   charCode,
    input  charPkg::glyphRow_t   glyphRow,
    output charPkg::glyphBits_t  glyphBits
);

    import charPkg::*;

    glyphBits_t [0:7] glyph; // Element 0 is the top row

    always_comb begin
        case (charCode)
            A: glyph = {8'b00011000, 8'b00111100, 8'b01100110, 8'b01100110,
                        8'b01111110, 8'b01100110, 8'b01100110, 8'b00000000};
            C: glyph = {8'b00111100, 8'b01100110, 8'b01100000, 8'b01100000,
                        8'b01100000, 8'b01100110, 8'b00111100, 8'b00000000};
            E: glyph = {8'b01111110, 8'b01100000, 8'b01100000, 8'b01111100,
                        8'b01100000, 8'b01100000, 8'b01111110, 8'b00000000};
            L: glyph = {8'b01100000, 8'b01100000, 8'b01100000, 8'b01100000,
                        8'b01100000, 8'b01100000, 8'b01111110, 8'b00000000};
            O: glyph = {8'b00111100, 8'b01100110, 8'b01100110, 8'b01100110,
                        8'b01100110, 8'b01100110, 8'b00111100, 8'b00000000};
            P: glyph = {8'b01111100, 8'b01100110, 8'b01100110, 8'b01111100,
                        8'b01100000, 8'b01100000, 8'b01100000, 8'b00000000};
            R: glyph = {8'b01111100, 8'b01100110, 8'b01100110, 8'b01111100,
                        8'b01111000, 8'b01101100, 8'b01100110, 8'b00000000};
            S: glyph = {8'b00111100, 8'b01100110, 8'b01100000, 8'b00111100,
                        8'b00000110, 8'b01100110, 8'b00111100, 8'b00000000};
            Y: glyph = {8'b01100110, 8'b01100110, 8'b01100110, 8'b00111100,
                        8'b00011000, 8'b00011000, 8'b00011000, 8'b00000000};
            default: glyph = '0; // SPACE and letters without a bitmap
        endcase
    end

    always_ff @(posedge clk) begin
        glyphBits <= glyph[glyphRow];
    end

endmodule

// File: design/textRenderer.sv
`timescale 1ns/1ns

module textRenderer (
    input  logic                  clk,
    input  logic                  rst,
    input  vgaTimingPkg::hCount_t  hCount,
    input  vgaTimingPkg::vCount_t  vCount,
    input  logic                  hsyncRaw,
    input  logic                  vsyncRaw,
    input  logic                  activeRaw,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  videoOn,
    output vgaTimingPkg::rgb_t     rgb
);

    import vgaTimingPkg::*;
    import charPkg::*;

    cellAddr_t cellAddr;
    charCode_t charCode;
    glyphBits_t glyphBits;
    glyphRow_t rowD1;
    logic [2:0] colD1;
    logic [2:0] colD2;
    logic inWindow;
    logic inWinD1;
    logic inWinD2;
    logic [PIPE_DELAY-1:0] hsyncPipe;
    logic [PIPE_DELAY-1:0] vsyncPipe;
    logic [PIPE_DELAY-1:0] activePipe;

    assign inWindow = (hCount < WINDOW_WIDTH) && (vCount < WINDOW_HEIGHT);
    assign cellAddr = {vCount[7:4], hCount[6:3]}; // Row = y/16, column = x/8

    menuTextRom textRom0 (
        .clk      (clk),
        .cellAddr (cellAddr),
        .charCode (charCode)
    );

    fontRom fontRom0 (
        .clk       (clk),
        .charCode  (charCode),
        .glyphRow  (rowD1),
        .glyphBits (glyphBits)
    );

    // Match the two ROM stages
    always_ff @(posedge clk) begin
        rowD1 <= vCount[3:1];
        colD1 <= hCount[2:0];
        colD2 <= colD1;
        inWinD1 <= inWindow;
        inWinD2 <= inWinD1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hsyncPipe <= '1;
            vsyncPipe <= '1;
            activePipe <= '0;
            rgb <= BG_COLOR;
        end else begin
            hsyncPipe <= {hsyncPipe[PIPE_DELAY-2:0], hsyncRaw};
            vsyncPipe <= {vsyncPipe[PIPE_DELAY-2:0], vsyncRaw};
            activePipe <= {activePipe[PIPE_DELAY-2:0], activeRaw};
            // Glyph bits arrive with the second stage of the delay lines
            if (activePipe[PIPE_DELAY-2] && inWinD2 && glyphBits[3'd7 - colD2]) begin
                rgb <= FG_COLOR;
            end else begin
                rgb <= BG_COLOR;
            end
        end
    end

    assign hsync = hsyncPipe[PIPE_DELAY-1];
    assign vsync = vsyncPipe[PIPE_DELAY-1];
    assign videoOn = activePipe[PIPE_DELAY-1];

endmodule

// File: design/textOverlayTop.sv
`timescale 1ns/1ns

module textOverlayTop (
    input  logic              clk,
    input  logic              rst,
    output logic              hsync,
    output logic              vsync,
    output logic              videoOn,
    output vgaTimingPkg::rgb_t rgb
);

    import vgaTimingPkg::*;

    hCount_t hCount;
    vCount_t vCount;
    logic hsyncRaw;
    logic vsyncRaw;
    logic activeRaw;

    syncGen syncGen0 (
        .clk       (clk),
        .rst       (rst),
        .hCount    (hCount),
        .vCount    (vCount),
        .hsyncRaw  (hsyncRaw),
        .vsyncRaw  (vsyncRaw),
        .activeRaw (activeRaw)
    );

    textRenderer textRenderer0 (
        .clk       (clk),
        .rst       (rst),
        .hCount    (hCount),
        .vCount    (vCount),
        .hsyncRaw  (hsyncRaw),
        .vsyncRaw  (vsyncRaw),
        .activeRaw (activeRaw),
        .hsync     (hsync),
        .vsync     (vsync),
        .videoOn   (videoOn),
        .rgb       (rgb)
    );

endmodule

// File: bench/textOverlayTb.sv
`timescale 1ns/1ns

module textOverlayTb;

    import vgaTimingPkg::*;
    import charPkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int FRAME_CLOCKS = H_TOTAL * V_TOTAL;
    localparam int TEST_COUNT = 6;

    logic clk;
    logic rst;
    logic hsync;
    logic vsync;
    logic videoOn;
    rgb_t rgb;

    int errs [1:TEST_COUNT];
    int cyc;
    logic prevH;
    logic prevV;
    logic prevOn;
    int lastHFall;
    int lastVFall;
    int onStart;
    int hPeriods;
    int vFalls;
    int lineCount;
    int xPos;
    int yPos;
    int windowPixels;
    bit lit [0:TEXT_ROWS-1][0:TEXT_COLS-1]; // Letter cells that showed a lit pixel

    textOverlayTop dut0 (
        .clk     (clk),
        .rst     (rst),
        .hsync   (hsync),
        .vsync   (vsync),
        .videoOn (videoOn),
        .rgb     (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Menu as it should read on screen with one string per text row
    function automatic byte menuChar(input int row, input int col);
        string line;
        case (row)
            0: line = " PLAY           ";
            2: line = " SCORE          ";
            default: line = "                ";
        endcase
        return line[col];
    endfunction

    task automatic checkValue(input int test, input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errs[test]++;
        end
    endtask

    task measureHsync;
        if (prevH && !hsync) begin
            if (lastHFall >= 0) begin
                checkValue(2, "hsync period", cyc - lastHFall, H_TOTAL);
                hPeriods++;
            end
            lastHFall = cyc;
        end
        if (!prevH && hsync && lastHFall >= 0) begin
            checkValue(2, "hsync low clocks", cyc - lastHFall, H_SYNC);
        end
    endtask

    task measureVsync;
        if (prevV && !vsync) begin
            if (vFalls > 0) begin
                checkValue(3, "vsync period", cyc - lastVFall, V_TOTAL * H_TOTAL);
                checkValue(4, "videoOn lines per frame", lineCount, V_ACTIVE);
            end
            vFalls++;
            lastVFall = cyc;
            lineCount = 0;
            yPos = -1;
        end
        if (!prevV && vsync && vFalls > 0) begin
            checkValue(3, "vsync low clocks", cyc - lastVFall, V_SYNC * H_TOTAL);
        end
    endtask

    task followVideoOn;
        if (!prevOn && videoOn) begin
            onStart = cyc;
            xPos = 0; // First pixel of a line
            yPos++;
            lineCount++;
        end else if (videoOn) begin
            xPos++;
        end
        // Line after reset starts one pixel late so only full frames count
        if (prevOn && !videoOn && vFalls > 0) begin
            checkValue(4, "videoOn high clocks", cyc - onStart, H_ACTIVE);
        end
    endtask

    task inspectPixel;
        assert (rgb == FG_COLOR || rgb == BG_COLOR) else begin
            $display("error rgb: got 0x%03h, expected 0x000 or 0xfff", rgb);
            errs[5]++;
        end
        if (!videoOn) begin
            checkValue(5, "rgb while blanked", int'(rgb), int'(BG_COLOR));
        end else if (vFalls > 0) begin
            if (xPos >= WINDOW_WIDTH || yPos >= WINDOW_HEIGHT) begin
                checkValue(5, "rgb outside window", int'(rgb), int'(BG_COLOR));
            end else begin
                windowPixels++;
                if (menuChar(yPos / CELL_HEIGHT, xPos / CELL_WIDTH) == " ") begin
                    checkValue(5, "rgb in blank cell", int'(rgb), int'(BG_COLOR));
                end else if (rgb == FG_COLOR) begin
                    lit[yPos / CELL_HEIGHT][xPos / CELL_WIDTH] = 1'b1;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            cyc++;
            measureHsync();
            measureVsync();
            followVideoOn();
            inspectPixel();
        end
        prevH = hsync;
        prevV = vsync;
        prevOn = videoOn;
    end

    task confirmLettersLit;
        for (int row = 0; row < TEXT_ROWS; row++) begin
            for (int col = 0; col < TEXT_COLS; col++) begin
                if (menuChar(row, col) != " ") begin
                    assert (lit[row][col]) else begin
                        $display("cell at row %0d column %0d never showed a lit pixel", row, col);
                        errs[6]++;
                    end
                end
            end
        end
    endtask

    task automatic waitVsyncFalls(input int count, input int limit, output bit ok);
        int n;
        n = 0;
        while (vFalls < count && n < limit) begin
            @(posedge clk);
            n++;
        end
        ok = (vFalls >= count);
    endtask

    task reportTest(input int test, input string name);
        if (errs[test] == 0) begin
            $display("[%0d] %s: ok", test, name);
        end else begin
            $display("[%0d] %s: %0d errors", test, name, errs[test]);
        end
    endtask

    initial begin
        bit ok;
        int failing;
        rst = 1'b1;
        cyc = 0;
        prevH = 1'b1;
        prevV = 1'b1;
        prevOn = 1'b0;
        lastHFall = -1;
        lastVFall = -1;
        onStart = 0;
        hPeriods = 0;
        vFalls = 0;
        lineCount = 0;
        xPos = 0;
        yPos = -1;
        windowPixels = 0;
        for (int i = 1; i <= TEST_COUNT; i++) begin
            errs[i] = 0;
        end
        for (int row = 0; row < TEXT_ROWS; row++) begin
            for (int col = 0; col < TEXT_COLS; col++) begin
                lit[row][col] = 1'b0;
            end
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk); // No clock edge since release yet
        checkValue(1, "hsync", int'(hsync), 1);
        checkValue(1, "vsync", int'(vsync), 1);
        checkValue(1, "videoOn", int'(videoOn), 0);
        checkValue(1, "rgb", int'(rgb), 0);
        reportTest(1, "reset state");

        // First vsync starts the measured frame and the second ends it
        waitVsyncFalls(1, 2 * FRAME_CLOCKS, ok);
        if (ok) begin
            waitVsyncFalls(2, FRAME_CLOCKS + H_TOTAL, ok);
        end
        if (ok) begin
            assert (hPeriods > 0) else begin
                $display("no full hsync period was measured");
                errs[2]++;
            end
            checkValue(5, "window pixel count", windowPixels, WINDOW_WIDTH * WINDOW_HEIGHT);
            confirmLettersLit();
        end else begin
            $display("timeout while waiting for two vsync pulses");
        end
        reportTest(2, "hsync timing");
        reportTest(3, "vsync timing");
        reportTest(4, "active video");
        reportTest(5, "pixel colours");
        reportTest(6, "menu letters");

        failing = 0;
        for (int i = 1; i <= TEST_COUNT; i++) begin
            if (errs[i] != 0) begin
                failing++;
            end
        end
        $display("tests run %0d, clean %0d, failing %0d, timed out %0d",
                 TEST_COUNT, TEST_COUNT - failing, failing, !ok);
        if (failing == 0 && ok) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: all.f
design/vgaTimingPkg.sv
design/charPkg.sv
design/syncGen.sv
design/menuTextRom.sv
design/fontRom.sv
design/textRenderer.sv
design/textOverlayTop.sv
bench/textOverlayTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module textOverlayTb -f all.f
./obj_dir/VtextOverlayTb > sim.log
cat sim.log

if grep -q "^test passed$" sim.log; then
    exit 0
else
    exit 1
fi
